/* dv/tb_load_store_unit.sv */
// testbench for the load/store unit: clock, reset, memory model, stimulus table, checks, LFSR
`timescale 1ns/10ps

module tb_load_store_unit;

    import riscv_pkg::*;
    import lsu_pkg::*;

    localparam int          MEM_WORDS = 16;
    localparam int          TIMEOUT   = 50;
    localparam logic [31:0] SEED      = 32'h6b0e;
    localparam int          NUM_STIM  = 25;

    typedef struct packed {
        lsu_op_e   op;
        xlen_t     a;
        xlen_t     imm;
        xlen_t     b;
        trans_id_t id;
    } stim_t;

    // operation, operand_a, imm, operand_b (store data), trans_id
    localparam stim_t STIM [NUM_STIM] = '{
        '{SW,  32'h0000_0010, 32'h0000_0000, 32'hdead_beef, 3'd1},
        '{LW,  32'h0000_0010, 32'h0000_0000, 32'h0000_0000, 3'd2},
        '{SB,  32'h0000_0020, 32'h0000_0001, 32'h0000_005a, 3'd3},
        '{SH,  32'h0000_0020, 32'h0000_0002, 32'h7777_c3e1, 3'd4},
        '{LW,  32'h0000_0020, 32'h0000_0000, 32'h0000_0000, 3'd5},
        '{LB,  32'h0000_0024, 32'h0000_0000, 32'h0000_0000, 3'd6},
        '{LB,  32'h0000_001c, 32'h0000_0005, 32'h0000_0000, 3'd7},
        '{LB,  32'h0000_0022, 32'h0000_0000, 32'h0000_0000, 3'd0},
        '{LBU, 32'h0000_0024, 32'hffff_ffff, 32'h0000_0000, 3'd1},
        '{LBU, 32'h0000_0020, 32'h0000_0000, 32'h0000_0000, 3'd2},
        '{LBU, 32'h0000_0021, 32'h0000_0000, 32'h0000_0000, 3'd3},
        '{LBU, 32'h0000_0012, 32'h0000_0000, 32'h0000_0000, 3'd4},
        '{LH,  32'h0000_0020, 32'h0000_0002, 32'h0000_0000, 3'd3},
        '{LHU, 32'h0000_0020, 32'h0000_0002, 32'h0000_0000, 3'd4},
        '{LH,  32'h0000_0030, 32'h0000_0000, 32'h0000_0000, 3'd5},
        '{LHU, 32'h0000_0034, 32'h0000_0000, 32'h0000_0000, 3'd6},
        '{LH,  32'h0000_0011, 32'h0000_0000, 32'h0000_0000, 3'd7},
        '{LW,  32'h0000_0012, 32'h0000_0000, 32'h0000_0000, 3'd0},
        '{SH,  32'h0000_0023, 32'h0000_0000, 32'h0000_1234, 3'd1},
        '{SW,  32'h0000_0040, 32'hffff_ffc2, 32'h5555_aaaa, 3'd2},
        '{SB,  32'h0000_003c, 32'h0000_0003, 32'h0000_0080, 3'd3},
        '{LB,  32'h0000_003f, 32'h0000_0000, 32'h0000_0000, 3'd4},
        '{LW,  32'h0000_003c, 32'h0000_0000, 32'h0000_0000, 3'd5},
        '{SH,  32'h0000_0008, 32'h0000_0000, 32'h1234_abcd, 3'd6},
        '{LW,  32'h0000_0008, 32'h0000_0000, 32'h0000_0000, 3'd7}
    };

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        lsu_valid;
    lsu_req_t    lsu_req;
    logic        lsu_ready;
    dmem_req_t   ld_req;
    dmem_req_t   st_req;
    dmem_rsp_t   ld_rsp = '0;
    dmem_rsp_t   st_rsp = '0;
    ld_wb_t      load_wb;
    st_wb_t      store_wb;

    // memory model and reference
    xlen_t       mem [MEM_WORDS];
    xlen_t       ref_mem [MEM_WORDS];
    dmem_req_t   ld_req_s;
    dmem_req_t   st_req_s;
    logic [31:0] lfsr_q = SEED;
    int          gnt_wait = -1;
    int          rd_wait = -1;
    xlen_t       rd_data;

    load_store_unit UUT (
        .clk_i         ( clk_i     ),
        .rst_ni        ( rst_ni    ),
        .lsu_valid_i   ( lsu_valid ),
        .lsu_req_i     ( lsu_req   ),
        .lsu_ready_o   ( lsu_ready ),
        .ld_dmem_req_o ( ld_req    ),
        .ld_dmem_rsp_i ( ld_rsp    ),
        .st_dmem_req_o ( st_req    ),
        .st_dmem_rsp_i ( st_rsp    ),
        .load_wb_o     ( load_wb   ),
        .store_wb_o    ( store_wb  )
    );

    always #20 clk_i = ~clk_i;

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit
    function automatic int take_bits(int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v      = (v << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    function automatic xlen_t fill_word(int i);
        return (xlen_t'(i) * 32'h9e37_79b9) ^ 32'hc4a5_1e73;
    endfunction

    function automatic int op_bytes(lsu_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            default:     return 4;
        endcase
    endfunction

    function automatic logic op_is_load(lsu_op_e op);
        return op inside {LB, LBU, LH, LHU, LW};
    endfunction

    // aligned loads only
    function automatic xlen_t expected_load(lsu_op_e op, xlen_t addr);
        xlen_t word;
        int    off;
        word = ref_mem[addr[5:2]];
        off  = int'(addr[1:0]);
        case (op)
            LB:      return {{24{word[8*off+7]}}, word[8*off +: 8]};
            LBU:     return {24'h0, word[8*off +: 8]};
            LH:      return {{16{word[8*off+15]}}, word[8*off +: 16]};
            LHU:     return {16'h0, word[8*off +: 16]};
            default: return word;
        endcase
    endfunction

    task automatic report_mismatch(string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "value check failed");
    endtask

    task automatic report_timeout(string what);
        $display("timeout while waiting for %s", what);
        $display("*** FAILED ***");
        $fatal(1, "wait timed out");
    endtask

    task automatic check_exception(exception_t ex, logic expect_ex, xlen_t cause, xlen_t tval);
        assert (ex.valid == expect_ex)
            else report_mismatch($sformatf("exception valid %0b, expected %0b", ex.valid,
                                           expect_ex));
        if (expect_ex) begin
            assert (ex.cause == cause && ex.tval == tval)
                else report_mismatch($sformatf("cause %0d tval %h, expected %0d %h",
                                               ex.cause, ex.tval, cause, tval));
        end
    endtask

    // ------------------------------------------------------------------
    // memory model answers requests sampled mid-cycle at the next edge
    // ------------------------------------------------------------------
    always @(negedge clk_i) begin
        ld_req_s <= ld_req;
        st_req_s <= st_req;
    end

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            ld_rsp   <= '0;
            st_rsp   <= '0;
            gnt_wait = -1;
            rd_wait  = -1;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] = fill_word(i);
            end
        end else begin
            ld_rsp.gnt    <= 1'b0;
            ld_rsp.rvalid <= 1'b0;
            st_rsp.gnt    <= 1'b0;
            if (st_rsp.gnt && st_req_s.req) begin
                assert (st_req_s.we)
                    else report_mismatch("store request without write enable");
                for (int k = 0; k < BYTES; k++) begin
                    if (st_req_s.be[k]) begin
                        mem[st_req_s.addr[5:2]][8*k +: 8] = st_req_s.wdata[8*k +: 8];
                    end
                end
            end else if (ld_rsp.gnt && ld_req_s.req) begin
                assert (!ld_req_s.we)
                    else report_mismatch("load request with write enable");
                rd_data = mem[ld_req_s.addr[5:2]];
                rd_wait = take_bits(2);
            end else if (ld_req_s.req || st_req_s.req) begin
                if (gnt_wait < 0) begin
                    gnt_wait = take_bits(2);
                end
                if (gnt_wait == 0) begin
                    ld_rsp.gnt <= ld_req_s.req;
                    st_rsp.gnt <= st_req_s.req;
                    gnt_wait = -1;
                end else begin
                    gnt_wait--;
                end
            end
            if (rd_wait == 0) begin
                ld_rsp.rvalid <= 1'b1;
                ld_rsp.rdata  <= rd_data;
                rd_wait = -1;
            end else if (rd_wait > 0) begin
                rd_wait--;
            end
        end
    end

    // ------------------------------------------------------------------
    // one table entry: issue, wait for writeback, check
    // ------------------------------------------------------------------
    task automatic run_op(input stim_t s);
        xlen_t addr;
        int    nbytes;
        logic  is_ld;
        logic  misaligned;
        xlen_t exp_result;
        be_t   exp_be;
        int    cycles;
        logic  wb_seen;

        addr       = s.a + s.imm;
        nbytes     = op_bytes(s.op);
        is_ld      = op_is_load(s.op);
        misaligned = (int'(addr[1:0]) % nbytes) != 0;
        exp_result = (is_ld && !misaligned) ? expected_load(s.op, addr) : '0;
        exp_be     = be_t'((1 << nbytes) - 1) << addr[1:0];

        @(posedge clk_i);
        lsu_valid         <= 1'b1;
        lsu_req.operation <= s.op;
        lsu_req.operand_a <= s.a;
        lsu_req.operand_b <= s.b;
        lsu_req.imm       <= s.imm;
        lsu_req.trans_id  <= s.id;
        cycles = 0;
        @(negedge clk_i);
        while (!lsu_ready) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                report_timeout("lsu_ready_o");
            end
            @(negedge clk_i);
        end
        @(posedge clk_i);
        lsu_valid <= 1'b0;

        cycles  = 0;
        wb_seen = 1'b0;
        while (!wb_seen) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_timeout("writeback valid");
            end
            if (misaligned) begin
                assert (!ld_req.req && !st_req.req)
                    else report_mismatch("memory request during misaligned operation");
            end
            if (ld_req.req) begin
                assert (ld_req.be == exp_be)
                    else report_mismatch($sformatf("load byte enables %b, expected %b",
                                                   ld_req.be, exp_be));
            end
            // unit still busy while memory holds it
            if (cycles == 1 || ld_req.req || st_req.req || rd_wait >= 0 || ld_rsp.rvalid) begin
                assert (!lsu_ready) else report_mismatch("lsu_ready_o high during operation");
            end
            assert (is_ld ? !store_wb.valid : !load_wb.valid)
                else report_mismatch("writeback on the wrong port");
            wb_seen = is_ld ? load_wb.valid : store_wb.valid;
        end

        if (misaligned) begin
            assert (cycles == 3)
                else report_mismatch($sformatf("misaligned writeback after %0d cycles", cycles));
        end
        if (is_ld) begin
            assert (load_wb.trans_id == s.id)
                else report_mismatch($sformatf("load trans_id %0d, expected %0d",
                                               load_wb.trans_id, s.id));
            assert (load_wb.result == exp_result)
                else report_mismatch($sformatf("load at %h returned %h, expected %h",
                                               addr, load_wb.result, exp_result));
            check_exception(load_wb.ex, misaligned, LD_ADDR_MISALIGNED, addr);
        end else begin
            assert (store_wb.trans_id == s.id)
                else report_mismatch($sformatf("store trans_id %0d, expected %0d",
                                               store_wb.trans_id, s.id));
            check_exception(store_wb.ex, misaligned, ST_ADDR_MISALIGNED, addr);
            if (!misaligned) begin
                for (int k = 0; k < nbytes; k++) begin
                    ref_mem[addr[5:2]][8*(int'(addr[1:0])+k) +: 8] = s.b[8*k +: 8];
                end
            end
        end
    endtask

    initial begin
        rst_ni    = 1'b0;
        lsu_valid = 1'b0;
        lsu_req   = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = fill_word(i);
        end
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        assert (lsu_ready && !load_wb.valid && !store_wb.valid && !ld_req.req && !st_req.req)
            else report_mismatch("outputs not idle after reset");
        for (int n = 0; n < NUM_STIM; n++) begin
            run_op(STIM[n]);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* load_store_unit.f */
source/riscv_pkg.sv
source/lsu_pkg.sv
source/pipe_reg.sv
source/lsu_agu.sv
source/load_unit.sv
source/store_unit.sv
source/load_store_unit.sv
dv/tb_load_store_unit.sv

/* run_verilator.sh */
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_load_store_unit \
    -f load_store_unit.f \
    && ./obj_dir/Vtb_load_store_unit \
    || { echo "simulation failed"; exit 1; }

/* source/load_store_unit.sv */
// load/store unit top with address stage, load and store units and writeback registers
`timescale 1ns/10ps

module load_store_unit (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               lsu_valid_i,
    input  lsu_pkg::lsu_req_t  lsu_req_i,
    output logic               lsu_ready_o,
    output lsu_pkg::dmem_req_t ld_dmem_req_o,
    input  lsu_pkg::dmem_rsp_t ld_dmem_rsp_i,
    output lsu_pkg::dmem_req_t st_dmem_req_o,
    input  lsu_pkg::dmem_rsp_t st_dmem_rsp_i,
    output lsu_pkg::ld_wb_t    load_wb_o,
    output lsu_pkg::st_wb_t    store_wb_o
);

    import lsu_pkg::*;

    lsu_ctrl_t lsu_ctrl;
    logic      ld_busy;
    logic      st_busy;
    ld_wb_t    ld_wb;
    st_wb_t    st_wb;

    // ------------------------------------------------------------------
    // address stage
    // ------------------------------------------------------------------
    lsu_agu i_lsu_agu (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .lsu_valid_i ( lsu_valid_i ),
        .lsu_req_i   ( lsu_req_i   ),
        .ld_busy_i   ( ld_busy     ),
        .st_busy_i   ( st_busy     ),
        .lsu_ready_o ( lsu_ready_o ),
        .lsu_ctrl_o  ( lsu_ctrl    )
    );

    // ------------------------------------------------------------------
    // load and store units, each with its own memory port
    // ------------------------------------------------------------------
    load_unit i_load_unit (
        .clk_i      ( clk_i         ),
        .rst_ni     ( rst_ni        ),
        .lsu_ctrl_i ( lsu_ctrl      ),
        .dmem_rsp_i ( ld_dmem_rsp_i ),
        .dmem_req_o ( ld_dmem_req_o ),
        .busy_o     ( ld_busy       ),
        .wb_o       ( ld_wb         )
    );

    store_unit i_store_unit (
        .clk_i      ( clk_i         ),
        .rst_ni     ( rst_ni        ),
        .lsu_ctrl_i ( lsu_ctrl      ),
        .dmem_rsp_i ( st_dmem_rsp_i ),
        .dmem_req_o ( st_dmem_req_o ),
        .busy_o     ( st_busy       ),
        .wb_o       ( st_wb         )
    );

    // ------------------------------------------------------------------
    // writeback pipeline registers
    // ------------------------------------------------------------------
    pipe_reg #(
        .payload_t ( ld_wb_t        ),
        .Depth     ( LOAD_PIPE_REGS )
    ) i_pipe_reg_load (
        .clk_i  ( clk_i     ),
        .rst_ni ( rst_ni    ),
        .d_i    ( ld_wb     ),
        .d_o    ( load_wb_o )
    );

    pipe_reg #(
        .payload_t ( st_wb_t         ),
        .Depth     ( STORE_PIPE_REGS )
    ) i_pipe_reg_store (
        .clk_i  ( clk_i      ),
        .rst_ni ( rst_ni     ),
        .d_i    ( st_wb      ),
        .d_o    ( store_wb_o )
    );

endmodule

/* source/load_unit.sv */
// load FSM, data memory read port and alignment with sign or zero extension
`timescale 1ns/10ps

module load_unit (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  lsu_pkg::lsu_ctrl_t lsu_ctrl_i,
    input  lsu_pkg::dmem_rsp_t dmem_rsp_i,
    output lsu_pkg::dmem_req_t dmem_req_o,
    output logic               busy_o,
    output lsu_pkg::ld_wb_t    wb_o
);

    import riscv_pkg::*;
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT_DATA
    } state_e;

    state_e     state_q;
    state_e     state_d;
    logic       take;
    logic       start;
    logic       data_in;
    // operation latched at the control pulse
    xlen_t      addr_q;
    be_t        be_q;
    size_e      size_q;
    logic       sign_q;
    logic [1:0] offset_q;
    trans_id_t  trans_id_q;
    exception_t ex_q;
    xlen_t      result_q;
    logic       wb_valid_q;

    // pick the addressed byte or half-word and extend it
    function automatic xlen_t align_load(xlen_t rdata, logic [1:0] offset, size_e size,
                                         logic sign);
        xlen_t shifted;
        shifted = rdata >> {offset, 3'b000};
        case (size)
            SIZE_BYTE: return {{(XLEN-8){sign & shifted[7]}}, shifted[7:0]};
            SIZE_HALF: return {{(XLEN-16){sign & shifted[15]}}, shifted[15:0]};
            default:   return shifted;
        endcase
    endfunction

    assign take    = lsu_ctrl_i.valid & lsu_ctrl_i.is_load;
    assign start   = take & ~lsu_ctrl_i.misaligned_ex.valid;
    assign data_in = (state_q == WAIT_DATA) & dmem_rsp_i.rvalid;

    // ------------------------------------------------------------------
    // request FSM
    // ------------------------------------------------------------------
    always_comb begin
        state_d    = state_q;
        dmem_req_o = '0;
        case (state_q)
            IDLE: begin
                // first request cycle is driven straight from the control word
                if (start) begin
                    dmem_req_o.req  = 1'b1;
                    dmem_req_o.addr = {lsu_ctrl_i.vaddr[XLEN-1:2], 2'b00};
                    dmem_req_o.be   = lsu_ctrl_i.be;
                    state_d         = dmem_rsp_i.gnt ? WAIT_DATA : REQUEST;
                end
            end
            REQUEST: begin
                dmem_req_o.req  = 1'b1;
                dmem_req_o.addr = addr_q;
                dmem_req_o.be   = be_q;
                if (dmem_rsp_i.gnt) begin
                    state_d = WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                if (dmem_rsp_i.rvalid) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            wb_valid_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            wb_valid_q <= data_in | (take & lsu_ctrl_i.misaligned_ex.valid);
        end
    end

    // payload, result stays zero for a misaligned load
    always_ff @(posedge clk_i) begin
        if (take) begin
            addr_q     <= {lsu_ctrl_i.vaddr[XLEN-1:2], 2'b00};
            be_q       <= lsu_ctrl_i.be;
            size_q     <= lsu_ctrl_i.size;
            sign_q     <= (lsu_ctrl_i.operation == LB) || (lsu_ctrl_i.operation == LH);
            offset_q   <= lsu_ctrl_i.vaddr[1:0];
            trans_id_q <= lsu_ctrl_i.trans_id;
            ex_q       <= lsu_ctrl_i.misaligned_ex;
            result_q   <= '0;
        end else if (data_in) begin
            result_q <= align_load(dmem_rsp_i.rdata, offset_q, size_q, sign_q);
        end
    end

    assign busy_o = (state_q != IDLE);

    always_comb begin
        wb_o.valid    = wb_valid_q;
        wb_o.trans_id = trans_id_q;
        wb_o.result   = result_q;
        wb_o.ex       = ex_q;
    end

endmodule

/* source/lsu_agu.sv */
// address generation, byte enables, misalignment check and control register stage
`timescale 1ns/10ps

module lsu_agu (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               lsu_valid_i,
    input  lsu_pkg::lsu_req_t  lsu_req_i,
    input  logic               ld_busy_i,
    input  logic               st_busy_i,
    output logic               lsu_ready_o,
    output lsu_pkg::lsu_ctrl_t lsu_ctrl_o
);

    import riscv_pkg::*;
    import lsu_pkg::*;

    xlen_t     vaddr;
    size_e     size;
    logic      is_load;
    logic      is_store;
    be_t       be;
    logic      misaligned;
    lsu_ctrl_t ctrl_d;
    lsu_ctrl_t ctrl_q;

    assign vaddr = lsu_req_i.operand_a + lsu_req_i.imm;

    // ------------------------------------------------------------------
    // operation decode
    // ------------------------------------------------------------------
    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        size     = SIZE_BYTE;
        case (lsu_req_i.operation)
            LB, LBU: is_load = 1'b1;
            LH, LHU: begin
                is_load = 1'b1;
                size    = SIZE_HALF;
            end
            LW: begin
                is_load = 1'b1;
                size    = SIZE_WORD;
            end
            SB: is_store = 1'b1;
            SH: begin
                is_store = 1'b1;
                size     = SIZE_HALF;
            end
            SW: begin
                is_store = 1'b1;
                size     = SIZE_WORD;
            end
            default: ;
        endcase
    end

    // byte enables at the address offset, plus alignment check
    always_comb begin
        case (size)
            SIZE_HALF: begin
                be         = be_t'(2'b11) << vaddr[1:0];
                misaligned = vaddr[0];
            end
            SIZE_WORD: begin
                be         = '1;
                misaligned = (vaddr[1:0] != 2'b00);
            end
            default: begin
                be         = be_t'(1'b1) << vaddr[1:0];
                misaligned = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // control register
    // ------------------------------------------------------------------
    always_comb begin
        ctrl_d               = '0;
        ctrl_d.valid         = lsu_valid_i & lsu_ready_o;
        ctrl_d.is_load       = is_load;
        ctrl_d.is_store      = is_store;
        ctrl_d.operation     = lsu_req_i.operation;
        ctrl_d.size          = size;
        ctrl_d.vaddr         = vaddr;
        ctrl_d.wdata         = lsu_req_i.operand_b;
        ctrl_d.be            = be;
        ctrl_d.trans_id      = lsu_req_i.trans_id;
        if (misaligned && (is_load || is_store)) begin
            ctrl_d.misaligned_ex.cause = is_load ? LD_ADDR_MISALIGNED : ST_ADDR_MISALIGNED;
            ctrl_d.misaligned_ex.tval  = vaddr;
            ctrl_d.misaligned_ex.valid = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= ctrl_d;
        end
    end

    // one operation in flight at a time
    assign lsu_ready_o = ~ctrl_q.valid & ~ld_busy_i & ~st_busy_i;
    assign lsu_ctrl_o  = ctrl_q;

endmodule

/* source/lsu_pkg.sv */
// request, control word, memory port and writeback structs, output pipeline depths
package lsu_pkg;

    import riscv_pkg::*;

    // ------------------------------------------------------------------
    // transaction ids
    // ------------------------------------------------------------------
    localparam int unsigned TRANS_ID_BITS = 3;

    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

    // ------------------------------------------------------------------
    // issue side
    // ------------------------------------------------------------------
    // operand_b carries the store data
    typedef struct packed {
        lsu_op_e   operation;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } lsu_req_t;

    // registered output of the address stage
    typedef struct packed {
        logic       valid;
        logic       is_load;
        logic       is_store;
        lsu_op_e    operation;
        size_e      size;
        xlen_t      vaddr;
        xlen_t      wdata;
        be_t        be;
        trans_id_t  trans_id;
        exception_t misaligned_ex;
    } lsu_ctrl_t;

    // ------------------------------------------------------------------
    // data memory ports
    // ------------------------------------------------------------------
    // addr is always word aligned
    typedef struct packed {
        logic  req;
        logic  we;
        xlen_t addr;
        be_t   be;
        xlen_t wdata;
    } dmem_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        xlen_t rdata;
    } dmem_rsp_t;

    // ------------------------------------------------------------------
    // writeback
    // ------------------------------------------------------------------
    typedef struct packed {
        logic       valid;
        trans_id_t  trans_id;
        xlen_t      result;
        exception_t ex;
    } ld_wb_t;

    typedef struct packed {
        logic       valid;
        trans_id_t  trans_id;
        exception_t ex;
    } st_wb_t;

    // register stages on each writeback path
    localparam int unsigned LOAD_PIPE_REGS  = 1;
    localparam int unsigned STORE_PIPE_REGS = 1;

endpackage

/* source/pipe_reg.sv */
// shift register of configurable depth for any packed payload, cleared on reset
`timescale 1ns/10ps

module pipe_reg #(
    parameter type         payload_t = logic,
    parameter int unsigned Depth     = 1
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  payload_t d_i,
    output payload_t d_o
);

    if (Depth == 0) begin : gen_pass
        assign d_o = d_i;
    end else begin : gen_regs
        payload_t stage_q [Depth];

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                for (int i = 0; i < Depth; i++) begin
                    stage_q[i] <= '0;
                end
            end else begin
                stage_q[0] <= d_i;
                // shift towards the output
                for (int i = 1; i < Depth; i++) begin
                    stage_q[i] <= stage_q[i-1];
                end
            end
        end

        assign d_o = stage_q[Depth-1];
    end

endmodule

/* source/riscv_pkg.sv */
// data width, load and store opcodes, transfer sizes and exception causes
package riscv_pkg;

    // ------------------------------------------------------------------
    // data path
    // ------------------------------------------------------------------
    localparam int unsigned XLEN  = 32;
    localparam int unsigned BYTES = XLEN / 8;

    typedef logic [XLEN-1:0]  xlen_t;
    typedef logic [BYTES-1:0] be_t;

    // ------------------------------------------------------------------
    // load/store operations
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        LB   = 4'd0,
        LBU  = 4'd1,
        LH   = 4'd2,
        LHU  = 4'd3,
        LW   = 4'd4,
        SB   = 4'd5,
        SH   = 4'd6,
        SW   = 4'd7,
        NONE = 4'd8
    } lsu_op_e;

    // width of one memory transfer
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_e;

    // ------------------------------------------------------------------
    // exceptions
    // ------------------------------------------------------------------
    localparam xlen_t LD_ADDR_MISALIGNED = xlen_t'(4);
    localparam xlen_t ST_ADDR_MISALIGNED = xlen_t'(6);

    // tval holds the faulting address
    typedef struct packed {
        xlen_t cause;
        xlen_t tval;
        logic  valid;
    } exception_t;

endpackage

/* source/store_unit.sv */
// store FSM, data memory write port and byte lane placement of store data
`timescale 1ns/10ps

module store_unit (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  lsu_pkg::lsu_ctrl_t lsu_ctrl_i,
    input  lsu_pkg::dmem_rsp_t dmem_rsp_i,
    output lsu_pkg::dmem_req_t dmem_req_o,
    output logic               busy_o,
    output lsu_pkg::st_wb_t    wb_o
);

    import riscv_pkg::*;
    import lsu_pkg::*;

    typedef enum logic {
        IDLE,
        REQUEST
    } state_e;

    state_e     state_q;
    state_e     state_d;
    logic       take;
    logic       start;
    logic       done;
    xlen_t      lane_data;
    xlen_t      addr_q;
    be_t        be_q;
    xlen_t      wdata_q;
    trans_id_t  trans_id_q;
    exception_t ex_q;
    logic       wb_valid_q;

    assign take      = lsu_ctrl_i.valid & lsu_ctrl_i.is_store;
    assign start     = take & ~lsu_ctrl_i.misaligned_ex.valid;
    assign lane_data = lsu_ctrl_i.wdata << {lsu_ctrl_i.vaddr[1:0], 3'b000};

    // ------------------------------------------------------------------
    // write request, held until granted
    // ------------------------------------------------------------------
    always_comb begin
        state_d    = state_q;
        done       = 1'b0;
        dmem_req_o = '0;
        case (state_q)
            IDLE: begin
                if (start) begin
                    dmem_req_o.req   = 1'b1;
                    dmem_req_o.we    = 1'b1;
                    dmem_req_o.addr  = {lsu_ctrl_i.vaddr[XLEN-1:2], 2'b00};
                    dmem_req_o.be    = lsu_ctrl_i.be;
                    dmem_req_o.wdata = lane_data;
                    done             = dmem_rsp_i.gnt;
                    state_d          = dmem_rsp_i.gnt ? IDLE : REQUEST;
                end
            end
            default: begin
                dmem_req_o.req   = 1'b1;
                dmem_req_o.we    = 1'b1;
                dmem_req_o.addr  = addr_q;
                dmem_req_o.be    = be_q;
                dmem_req_o.wdata = wdata_q;
                done             = dmem_rsp_i.gnt;
                state_d          = dmem_rsp_i.gnt ? IDLE : REQUEST;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            wb_valid_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            wb_valid_q <= done | (take & lsu_ctrl_i.misaligned_ex.valid);
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            addr_q     <= {lsu_ctrl_i.vaddr[XLEN-1:2], 2'b00};
            be_q       <= lsu_ctrl_i.be;
            wdata_q    <= lane_data;
            trans_id_q <= lsu_ctrl_i.trans_id;
            ex_q       <= lsu_ctrl_i.misaligned_ex;
        end
    end

    assign busy_o = (state_q == REQUEST);

    always_comb begin
        wb_o.valid    = wb_valid_q;
        wb_o.trans_id = trans_id_q;
        wb_o.ex       = ex_q;
    end

endmodule
